// ==== files.f ====
hw/mduPkg.sv
hw/mduDispatch.sv
hw/multiplier.sv
hw/divider.sv
hw/mduWriteback.sv
hw/mdu.sv
test/mduTb.sv

// ==== hw/divider.sv ====
`timescale 1ns/100ps

module divider import mduPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  MduReq    req,
    input  logic     granted,
    output MduResult res,
    output logic     busy
);

    divState                state;
    logic [divCntWidth-1:0] cnt;
    MduReq                  cur;
    logic [dataWidth-1:0]   rem;
    logic [dataWidth-1:0]   quot;
    logic [dataWidth-1:0]   divisor;
    logic [dataWidth-1:0]   aMag;
    logic [dataWidth-1:0]   bMag;
    logic [dataWidth:0]     shifted;
    logic [dataWidth:0]     trial;
    logic                   negQ;
    logic                   negR;

    assign aMag = (req.signedOp && req.a[dataWidth-1]) ? -req.a : req.a;
    assign bMag = (req.signedOp && req.b[dataWidth-1]) ? -req.b : req.b;

    // Quotient sign from both operands, remainder follows the dividend
    assign negQ = cur.signedOp & (cur.a[dataWidth-1] ^ cur.b[dataWidth-1]);
    assign negR = cur.signedOp & cur.a[dataWidth-1];

    assign shifted = {rem, quot[dataWidth-1]};
    assign trial   = shifted - {1'b0, divisor};

    // Pending request counts too, so a second divide is held back at once
    assign busy = (state != DIV_IDLE) | req.valid;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (req.valid) begin
                    cur     <= req;
                    rem     <= '0;
                    quot    <= aMag;
                    divisor <= bMag;
                end
            end
            DIV_RUN: begin
                // Restore on a negative trial
                rem  <= trial[dataWidth] ? shifted[dataWidth-1:0] : trial[dataWidth-1:0];
                quot <= {quot[dataWidth-2:0], ~trial[dataWidth]};
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control and result
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= DIV_IDLE;
            cnt   <= '0;
            res   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (req.valid) begin
                        state <= DIV_RUN;
                        cnt   <= divCntWidth'(divCycles - 1);
                    end
                end
                DIV_RUN: begin
                    if (cnt == '0) begin
                        state <= DIV_FIX;
                    end
                    cnt <= cnt - 1'b1;
                end
                DIV_FIX: begin
                    state     <= DIV_HOLD;
                    res.valid <= 1'b1;
                    res.idHi  <= cur.idHi;
                    res.idLo  <= cur.idLo;
                    res.dstHi <= cur.dstHi;
                    res.dstLo <= cur.dstLo;
                    if (cur.b == '0) begin
                        res.lo <= '1;
                        res.hi <= cur.a;
                    end else begin
                        res.lo <= negQ ? -quot : quot;
                        res.hi <= negR ? -rem : rem;
                    end
                end
                DIV_HOLD: begin
                    if (granted) begin
                        state     <= DIV_IDLE;
                        res.valid <= 1'b0;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/mdu.sv ====
`timescale 1ns/100ps

module mdu import mduPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  UOPBundle uopHi,
    input  UOPBundle uopLo,
    input  PRFrData  rdata,
    output PRFwInfo  wbData,
    output FuRobInfo robDone,
    output logic     mulBusy,
    output logic     divBusy
);

    MduReq    mulReq;
    MduReq    divReq;
    MduResult mulRes;
    MduResult divRes;
    logic     mulStall;
    logic     divGranted;

    mduDispatch dispatch (
        .clk    (clk),
        .rstN   (rstN),
        .uopHi  (uopHi),
        .uopLo  (uopLo),
        .rdata  (rdata),
        .mulReq (mulReq),
        .divReq (divReq)
    );

    multiplier mul (
        .clk   (clk),
        .rstN  (rstN),
        .req   (mulReq),
        .stall (mulStall),
        .res   (mulRes)
    );

    divider div (
        .clk     (clk),
        .rstN    (rstN),
        .req     (divReq),
        .granted (divGranted),
        .res     (divRes),
        .busy    (divBusy)
    );

    mduWriteback writeback (
        .mulRes     (mulRes),
        .divRes     (divRes),
        .wbData     (wbData),
        .robDone    (robDone),
        .mulStall   (mulStall),
        .divGranted (divGranted)
    );

    // Issuer holds multiplies while a stalled result waits
    assign mulBusy = mulStall;

endmodule

// ==== hw/mduDispatch.sv ====
`timescale 1ns/100ps

module mduDispatch import mduPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  UOPBundle uopHi,
    input  UOPBundle uopLo,
    input  PRFrData  rdata,
    output MduReq    mulReq,
    output MduReq    divReq
);

    logic     pairValid;
    UOPBundle hiQ;
    UOPBundle loQ;
    PRFrData  rdataQ;
    logic     isDiv;
    logic     signedOp;
    MduReq    req;

    // Half a pair is malformed and never makes it past here
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pairValid <= 1'b0;
        end else begin
            pairValid <= uopHi.valid & uopLo.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uopHi.valid && uopLo.valid) begin
            hiQ    <= uopHi;
            loQ    <= uopLo;
            rdataQ <= rdata;
        end
    end

    always_comb begin
        case (hiQ.op)
            MDU_MULT:  {isDiv, signedOp} = 2'b01;
            MDU_MULTU: {isDiv, signedOp} = 2'b00;
            MDU_DIV:   {isDiv, signedOp} = 2'b11;
            default:   {isDiv, signedOp} = 2'b10;
        endcase
    end

    assign req = '{valid: pairValid, signedOp: signedOp,
                   a: rdataQ.rs, b: rdataQ.rt,
                   idHi: hiQ.id, idLo: loQ.id,
                   dstHi: hiQ.dst, dstLo: loQ.dst};

    // Same payload to both units, only one sees valid
    always_comb begin
        mulReq       = req;
        divReq       = req;
        mulReq.valid = pairValid & ~isDiv;
        divReq.valid = pairValid & isDiv;
    end

endmodule

// ==== hw/mduPkg.sv ====
package mduPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and counts
    ////////////////////////////////////////////////////////////////////////////
    localparam int dataWidth   = 32;
    localparam int robIdWidth  = 12;
    localparam int prfIdWidth  = 6;
    localparam int divCycles   = 32;
    localparam int divCntWidth = $clog2(divCycles);

    typedef enum logic [1:0] {
        MDU_MULT  = 2'd0,
        MDU_MULTU = 2'd1,
        MDU_DIV   = 2'd2,
        MDU_DIVU  = 2'd3
    } mduOp;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_FIX  = 2'd2,
        DIV_HOLD = 2'd3
    } divState;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles between the core and the unit
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                  valid;
        mduOp                  op;
        logic [robIdWidth-1:0] id;
        logic [prfIdWidth-1:0] dst;
    } UOPBundle;

    typedef struct packed {
        logic [dataWidth-1:0] rs;
        logic [dataWidth-1:0] rt;
    } PRFrData;

    // One operation, both halves of the pair
    typedef struct packed {
        logic                  valid;
        logic                  signedOp;
        logic [dataWidth-1:0]  a;
        logic [dataWidth-1:0]  b;
        logic [robIdWidth-1:0] idHi;
        logic [robIdWidth-1:0] idLo;
        logic [prfIdWidth-1:0] dstHi;
        logic [prfIdWidth-1:0] dstLo;
    } MduReq;

    typedef struct packed {
        logic                  valid;
        logic [dataWidth-1:0]  hi;
        logic [dataWidth-1:0]  lo;
        logic [robIdWidth-1:0] idHi;
        logic [robIdWidth-1:0] idLo;
        logic [prfIdWidth-1:0] dstHi;
        logic [prfIdWidth-1:0] dstLo;
    } MduResult;

    typedef struct packed {
        logic                  we;
        logic [prfIdWidth-1:0] dstHi;
        logic [prfIdWidth-1:0] dstLo;
        logic [dataWidth-1:0]  hi;
        logic [dataWidth-1:0]  lo;
    } PRFwInfo;

    typedef struct packed {
        logic                  valid;
        logic [robIdWidth-1:0] idHi;
        logic [robIdWidth-1:0] idLo;
    } FuRobInfo;

endpackage

// ==== hw/mduWriteback.sv ====
`timescale 1ns/100ps

module mduWriteback import mduPkg::*; (
    input  MduResult mulRes,
    input  MduResult divRes,
    output PRFwInfo  wbData,
    output FuRobInfo robDone,
    output logic     mulStall,
    output logic     divGranted
);

    MduResult selRes;

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////

    // Divider wins, multiplier waits a cycle
    always_comb begin
        if (divRes.valid) begin
            selRes = divRes;
        end else begin
            selRes = mulRes;
        end
    end

    assign mulStall   = mulRes.valid & divRes.valid;
    assign divGranted = divRes.valid;

    ////////////////////////////////////////////////////////////////////////////
    // Register file write and ROB completion
    ////////////////////////////////////////////////////////////////////////////

    // Both halves go out in the same cycle
    assign wbData = '{
        we:    selRes.valid,
        dstHi: selRes.dstHi,
        dstLo: selRes.dstLo,
        hi:    selRes.hi,
        lo:    selRes.lo
    };

    assign robDone = '{
        valid: selRes.valid,
        idHi:  selRes.idHi,
        idLo:  selRes.idLo
    };

endmodule

// ==== hw/multiplier.sv ====
`timescale 1ns/100ps

module multiplier import mduPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  MduReq    req,
    input  logic     stall,
    output MduResult res
);

    MduReq                  skid;
    MduReq                  inReq;
    MduReq                  s1;
    logic                   neg1;
    MduResult               s2;
    logic                   neg2;
    logic [dataWidth-1:0]   aAbs;
    logic [dataWidth-1:0]   bAbs;

    // A request landing in a stall cycle waits here for one cycle
    assign inReq = skid.valid ? skid : req;

    assign aAbs = (inReq.signedOp && inReq.a[dataWidth-1]) ? -inReq.a : inReq.a;
    assign bAbs = (inReq.signedOp && inReq.b[dataWidth-1]) ? -inReq.b : inReq.b;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            skid <= '0;
            s1   <= '0;
            neg1 <= 1'b0;
            s2   <= '0;
            neg2 <= 1'b0;
            res  <= '0;
        end else if (stall) begin
            skid <= req;
        end else begin
            skid.valid <= 1'b0;

            // Stage one, magnitudes and product sign
            s1   <= inReq;
            s1.a <= aAbs;
            s1.b <= bAbs;
            neg1 <= inReq.signedOp & (inReq.a[dataWidth-1] ^ inReq.b[dataWidth-1]);

            // Stage two, unsigned product
            s2.valid       <= s1.valid;
            {s2.hi, s2.lo} <= s1.a * s1.b;
            s2.idHi        <= s1.idHi;
            s2.idLo        <= s1.idLo;
            s2.dstHi       <= s1.dstHi;
            s2.dstLo       <= s1.dstLo;
            neg2           <= neg1;

            // Stage three, restore sign
            res              <= s2;
            {res.hi, res.lo} <= neg2 ? -{s2.hi, s2.lo} : {s2.hi, s2.lo};
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the MDU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module mduTb \
        -f files.f -o mduSim; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/mduSim); then
    printf '%s\n' "$out"
    echo "simulation exited with an error"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^ALL TESTS PASSED$"; then
    exit 0
fi
exit 1

// ==== test/mduTb.sv ====
`timescale 1ns/100ps

module mduTb import mduPkg::*; ();

    localparam int idSpace        = 1 << robIdWidth;
    localparam int nRandMul       = 200;
    localparam int nRandDiv       = 20;
    localparam int overlapRounds  = 3;
    localparam int overlapCycles  = 40;
    localparam int totalOps       = 16 + nRandMul + nRandDiv + 4
                                    + overlapRounds * overlapCycles + 1;
    localparam int watchdogCycles = totalOps * 40 + 200;

    // Fixed multiply operands with the signed extremes
    localparam logic [dataWidth-1:0] fixA [8] = '{32'd3, 32'hffff_fff9, 32'hffff_ffff,
        32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'd123456};
    localparam logic [dataWidth-1:0] fixB [8] = '{32'd5, 32'd6, 32'hffff_ffff,
        32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0001, 32'hfffe_7e33};

    logic     clk     = 1'b0;
    logic     rstN    = 1'b0;
    UOPBundle uopHi   = '0;
    UOPBundle uopLo   = '0;
    PRFrData  rdata   = '0;
    PRFwInfo  wbData;
    FuRobInfo robDone;
    logic     mulBusy;
    logic     divBusy;

    integer seed = 32'h8980df8c;

    // Scoreboard indexed by idHi
    logic [dataWidth-1:0]  expHi    [idSpace];
    logic [dataWidth-1:0]  expLo    [idSpace];
    logic [robIdWidth-1:0] expIdLo  [idSpace];
    logic [prfIdWidth-1:0] expDstHi [idSpace];
    logic [prfIdWidth-1:0] expDstLo [idSpace];
    string                 testName [idSpace];
    logic                  issued   [idSpace] = '{default: 1'b0};
    logic                  isDivOp  [idSpace] = '{default: 1'b0};
    int                    doneCnt  [idSpace] = '{default: 0};

    logic [robIdWidth-1:0] nextId         = '0;
    string                 curTest        = "reset";
    int                    issuedCount    = 0;
    int                    completed      = 0;
    int                    cycle          = 0;
    int                    stallCount     = 0;
    int                    valueErrors    = 0;
    int                    protocolErrors = 0;
    logic                  divWrittenLast = 1'b0;
    logic                  mulWaitLast    = 1'b0;

    mdu uut (
        .clk     (clk),
        .rstN    (rstN),
        .uopHi   (uopHi),
        .uopLo   (uopLo),
        .rdata   (rdata),
        .wbData  (wbData),
        .robDone (robDone),
        .mulBusy (mulBusy),
        .divBusy (divBusy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and reporting
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [2*dataWidth-1:0] refResult(input mduOp op,
            input logic [dataWidth-1:0] rs, input logic [dataWidth-1:0] rt);
        logic signed [dataWidth-1:0]   sRs;
        logic signed [dataWidth-1:0]   sRt;
        logic signed [2*dataWidth-1:0] sProd;
        logic [dataWidth-1:0]          q;
        logic [dataWidth-1:0]          r;
        sRs = rs;
        sRt = rt;
        case (op)
            MDU_MULT: begin
                sProd = sRs * sRt;
                return sProd;
            end
            MDU_MULTU: return {{dataWidth{1'b0}}, rs} * {{dataWidth{1'b0}}, rt};
            default: begin
                if (rt == '0) begin
                    return {rs, {dataWidth{1'b1}}};
                end
                // Signed overflow case
                if (op == MDU_DIV && rs == 32'h8000_0000 && rt == '1) begin
                    return {{dataWidth{1'b0}}, rs};
                end
                if (op == MDU_DIV) begin
                    q = sRs / sRt;
                    r = sRs % sRt;
                end else begin
                    q = rs / rt;
                    r = rs % rt;
                end
                return {r, q};
            end
        endcase
    endfunction

    task automatic reportValue(input logic [robIdWidth-1:0] id, input string field,
            input logic [dataWidth-1:0] expVal, input logic [dataWidth-1:0] actVal);
        valueErrors++;
        $display("error %s id %0d %s: expected %h, actual %h",
                 testName[id], id, field, expVal, actVal);
    endtask

    task automatic reportProtocol(input string msg);
        protocolErrors++;
        $display("%s", msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic presentPair(input mduOp op, input logic [dataWidth-1:0] rs,
                               input logic [dataWidth-1:0] rt);
        logic [2*dataWidth-1:0] expVal;
        logic [prfIdWidth-1:0]  dHi;
        logic [prfIdWidth-1:0]  dLo;
        expVal = refResult(op, rs, rt);
        dHi = prfIdWidth'($random(seed));
        dLo = prfIdWidth'($random(seed));
        expHi[nextId]    = expVal[2*dataWidth-1:dataWidth];
        expLo[nextId]    = expVal[dataWidth-1:0];
        expIdLo[nextId]  = nextId + robIdWidth'(1);
        expDstHi[nextId] = dHi;
        expDstLo[nextId] = dLo;
        isDivOp[nextId]  = (op == MDU_DIV) || (op == MDU_DIVU);
        testName[nextId] = curTest;
        issued[nextId]   = 1'b1;
        uopHi <= '{valid: 1'b1, op: op, id: nextId, dst: dHi};
        uopLo <= '{valid: 1'b1, op: op, id: nextId + robIdWidth'(1), dst: dLo};
        rdata <= '{rs: rs, rt: rt};
        nextId      = nextId + robIdWidth'(2);
        issuedCount = issuedCount + 1;
    endtask

    task automatic clearInputs();
        uopHi <= '0;
        uopLo <= '0;
    endtask

    task automatic waitDrain();
        while (completed != issuedCount) @(posedge clk);
    endtask

    task automatic checkIdleOutputs(input string when);
        assert (!wbData.we && !robDone.valid && !mulBusy && !divBusy)
            else reportProtocol($sformatf("outputs not idle %s", when));
    endtask

    // One divide at a time with busy expected right after dispatch
    task automatic runDivide(input mduOp op, input logic [dataWidth-1:0] a,
                             input logic [dataWidth-1:0] b);
        @(posedge clk);
        presentPair(op, a, b);
        @(posedge clk);
        clearInputs();
        @(posedge clk);
        assert (divBusy)
            else reportProtocol($sformatf("%s: divBusy low after a divide issued", curTest));
        waitDrain();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Writeback checker
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : checkWrites
        logic [robIdWidth-1:0] id;
        id = robDone.idHi;
        if (rstN) begin
            if (divWrittenLast) begin
                assert (!divBusy) else reportProtocol("divBusy still high after divide write");
            end
            divWrittenLast = wbData.we && isDivOp[id];
            // Held multiply result goes out right after the stall
            if (mulWaitLast) begin
                assert (wbData.we && !isDivOp[id])
                    else reportProtocol("held multiply result not written after the stall");
            end
            mulWaitLast = mulBusy;
            if (mulBusy) begin
                stallCount++;
                assert (wbData.we && isDivOp[id])
                    else reportProtocol("mulBusy high without a divide write");
            end
            if (wbData.we) begin
                assert (robDone.valid) else reportProtocol("robDone.valid low on a write");
                assert (issued[id] && doneCnt[id] == 0)
                    else reportProtocol($sformatf("unexpected or repeated write for id %0d", id));
                if (issued[id]) begin
                    if (doneCnt[id] == 0) begin
                        completed <= completed + 1;
                    end
                    doneCnt[id]++;
                    assert (wbData.hi == expHi[id])
                        else reportValue(id, "hi", expHi[id], wbData.hi);
                    assert (wbData.lo == expLo[id])
                        else reportValue(id, "lo", expLo[id], wbData.lo);
                    assert (robDone.idLo == expIdLo[id])
                        else reportValue(id, "idLo", 32'(expIdLo[id]), 32'(robDone.idLo));
                    assert (wbData.dstHi == expDstHi[id])
                        else reportValue(id, "dstHi", 32'(expDstHi[id]), 32'(wbData.dstHi));
                    assert (wbData.dstLo == expDstLo[id])
                        else reportValue(id, "dstLo", 32'(expDstLo[id]), 32'(wbData.dstLo));
                end
            end else begin
                assert (!robDone.valid) else reportProtocol("robDone.valid high without a write");
            end
        end
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", watchdogCycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin : mainSeq
        int k;
        int r;
        int blockCycle;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;

        for (k = 0; k < 10; k++) begin
            @(posedge clk);
            if (k > 0) begin
                checkIdleOutputs("during reset");
            end
        end
        rstN <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            checkIdleOutputs("after reset");
        end

        curTest = "mul fixed";
        for (k = 0; k < 16; k++) begin
            @(posedge clk);
            presentPair(k[0] ? MDU_MULTU : MDU_MULT, fixA[k/2], fixB[k/2]);
        end
        curTest = "mul random";
        for (k = 0; k < nRandMul; k++) begin
            @(posedge clk);
            presentPair(k[0] ? MDU_MULTU : MDU_MULT, $random(seed), $random(seed));
        end
        @(posedge clk);
        clearInputs();
        waitDrain();

        curTest = "div random";
        for (k = 0; k < nRandDiv; k++) begin
            a = $random(seed);
            b = $random(seed);
            if (k % 3 == 0) begin
                b = b >> 20;
            end
            runDivide(k[0] ? MDU_DIVU : MDU_DIV, a, b);
        end
        curTest = "div special";
        runDivide(MDU_DIV, 32'hffff_ff9c, '0);
        runDivide(MDU_DIVU, 32'h1234_5678, '0);
        runDivide(MDU_DIV, 32'h8000_0000, 32'hffff_ffff);
        runDivide(MDU_DIVU, 32'h8000_0000, 32'hffff_ffff);

        // Multiplies every cycle except the one where the divide takes writeback
        curTest = "overlap";
        for (r = 0; r < overlapRounds; r++) begin
            @(posedge clk);
            blockCycle = cycle + 35;
            presentPair(MDU_DIV, $random(seed), $random(seed));
            for (k = 0; k < overlapCycles; k++) begin
                @(posedge clk);
                if (cycle == blockCycle) begin
                    clearInputs();
                end else begin
                    presentPair(k[0] ? MDU_MULTU : MDU_MULT, $random(seed), $random(seed));
                end
            end
            @(posedge clk);
            clearInputs();
            waitDrain();
        end
        // One conflict per round
        assert (stallCount == overlapRounds)
            else reportProtocol($sformatf("error %s stall count: expected %0d, actual %0d",
                                          curTest, overlapRounds, stallCount));

        // Half a pair must never complete
        curTest = "malformed";
        @(posedge clk);
        uopHi <= '{valid: 1'b1, op: MDU_MULT, id: nextId, dst: 6'd1};
        uopLo <= '0;
        rdata <= '{rs: 32'd7, rt: 32'd9};
        nextId = nextId + robIdWidth'(2);
        @(posedge clk);
        clearInputs();
        repeat (50) @(posedge clk);

        for (k = 0; k < idSpace; k++) begin
            if (issued[k]) begin
                assert (doneCnt[k] == 1)
                    else reportProtocol($sformatf("id %0d completed %0d times", k, doneCnt[k]));
            end
        end
        $display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
